//--- vlog.f
rtl/regPkg.sv
rtl/ctrlPkg.sv
rtl/destIf.sv
rtl/destPipe.sv
rtl/hazardUnit.sv
rtl/operandForward.sv
rtl/pipeCtrlTop.sv
testbench/pipeCtrlTb.sv

//--- Bender.yml
package:
  name: pipeCtrl

sources:
  - rtl/regPkg.sv
  - rtl/ctrlPkg.sv
  - rtl/destIf.sv
  - rtl/destPipe.sv
  - rtl/hazardUnit.sv
  - rtl/operandForward.sv
  - rtl/pipeCtrlTop.sv
  - target: test
    files:
      - testbench/pipeCtrlTb.sv

//--- testbench/pipeCtrlTb.sv
`timescale 1ns/1ns

module pipeCtrlTb;

    localparam int clkPeriod  = 40;
    localparam int driveDelay = 5;
    localparam int sampleWait = 30;  // lands 5 ns before the next edge

    // decode flags as {regWrite, memRead, isMfc}
    localparam logic [2:0] decNone  = 3'b000;
    localparam logic [2:0] decWrite = 3'b100;
    localparam logic [2:0] decLoad  = 3'b110;
    localparam logic [2:0] decMfc   = 3'b101;

    localparam logic [7:0] reqNone    = 8'h00;
    localparam logic [7:0] reqICache  = 8'h80;
    localparam logic [7:0] reqDCache  = 8'h40;
    localparam logic [7:0] reqAlu     = 8'h20;
    localparam logic [7:0] reqBlank   = 8'h10;
    localparam logic [7:0] reqJump    = 8'h08;
    localparam logic [7:0] reqTaken   = 8'h04;
    localparam logic [7:0] reqMispred = 8'h02;
    localparam logic [7:0] reqExc     = 8'h01;

    localparam ctrlPkg::fwdSel selNone = ctrlPkg::fwdNone;
    localparam ctrlPkg::fwdSel selW    = ctrlPkg::fwdW;
    localparam ctrlPkg::fwdSel selM2   = ctrlPkg::fwdM2;
    localparam ctrlPkg::fwdSel selM    = ctrlPkg::fwdM;
    localparam ctrlPkg::fwdSel selE    = ctrlPkg::fwdE;

    typedef struct packed {
        regPkg::regAddr    srcA;
        regPkg::regAddr    srcB;
        regPkg::regAddr    dstD;
        logic [2:0]        dec;
        logic [7:0]        req;
        ctrlPkg::fwdSel    expSelA;
        ctrlPkg::fwdSel    expSelB;
        ctrlPkg::stallMask expStall;
        ctrlPkg::flushMask expFlush;
        logic              expLoadUse;
    } testRow;

    testRow rows[$];
    string  rowNames[$];
    int     errorCount = 0;
    int     checkCount = 0;
    bit     tableBuilt = 1'b0;

    logic clk, rstN;
    regPkg::regAddr srcA, srcB, dstD;
    logic regWriteD, memReadD, isMfcD;
    logic iCacheStall, dCacheStall, aluStallE, blankSl;
    logic jumpD, predTakeD, flushPredFailedE, flushExceptionM;
    regPkg::dataWord regFileA, regFileB, resultE, resultM, resultM2, resultW;
    ctrlPkg::stallMask stall;
    ctrlPkg::flushMask flush;
    ctrlPkg::fwdSel fwdSelA, fwdSelB;
    regPkg::dataWord operandA, operandB;
    logic loadUseStall, longestStall, icacheCtl;

    pipeCtrlTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkSel(input string name, input string what,
                            input ctrlPkg::fwdSel expected, input ctrlPkg::fwdSel actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: %s expected %0d actual %0d", name, what, expected, actual);
        end
    endtask

    task automatic checkWord(input string name, input string what,
                             input regPkg::dataWord expected, input regPkg::dataWord actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic checkStall(input string name, input ctrlPkg::stallMask expected,
                              input ctrlPkg::stallMask actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: stall expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic checkFlush(input string name, input ctrlPkg::flushMask expected,
                              input ctrlPkg::flushMask actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: flush expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input string what,
                            input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: %s expected %b actual %b", name, what, expected, actual);
        end
    endtask

    task automatic addRow(input string name,
                          input regPkg::regAddr a, input regPkg::regAddr b,
                          input regPkg::regAddr d, input logic [2:0] dec, input logic [7:0] req,
                          input ctrlPkg::fwdSel selA, input ctrlPkg::fwdSel selB,
                          input ctrlPkg::stallMask st, input ctrlPkg::flushMask fl,
                          input logic lu);
        testRow row;
        row.srcA       = a;
        row.srcB       = b;
        row.dstD       = d;
        row.dec        = dec;
        row.req        = req;
        row.expSelA    = selA;
        row.expSelB    = selB;
        row.expStall   = st;
        row.expFlush   = fl;
        row.expLoadUse = lu;
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    // stall hex is W down to F and flush hex is M2 down to F2
    // comments give the pipe state before the row
    task automatic buildTable();
        addRow("reset", 1, 2, 0, decNone, reqNone, selNone, selNone, 7'h00, 5'h00, 0);
        addRow("write r5", 5, 0, 5, decWrite, reqNone, selNone, selNone, 7'h00, 5'h00, 0);
        addRow("fwd E", 5, 0, 5, decWrite, reqNone, selE, selNone, 7'h00, 5'h00, 0);
        addRow("E over M", 5, 5, 6, decWrite, reqNone, selE, selE, 7'h00, 5'h00, 0);
        addRow("fwd M", 5, 6, 0, decNone, reqNone, selM, selE, 7'h00, 5'h00, 0);
        addRow("fwd M2", 5, 6, 0, decNone, reqNone, selM2, selM, 7'h00, 5'h00, 0);
        addRow("fwd W", 5, 6, 0, decWrite, reqNone, selW, selM2, 7'h00, 5'h00, 0);
        // r0 write now sits in E
        addRow("zero no fwd", 6, 0, 7, decLoad, reqNone, selW, selNone, 7'h00, 5'h00, 0);
        addRow("load use E", 7, 0, 8, decWrite, reqNone, selE, selNone, 7'h07, 5'h04, 1);
        addRow("load use M", 7, 0, 8, decWrite, reqNone, selM, selNone, 7'h07, 5'h04, 1);
        addRow("load done", 7, 0, 8, decWrite, reqNone, selM2, selNone, 7'h00, 5'h00, 0);
        addRow("mfc0 issue", 0, 0, 9, decMfc, reqNone, selNone, selNone, 7'h00, 5'h00, 0);
        addRow("mfc0 use E", 0, 9, 10, decWrite, reqNone, selNone, selE, 7'h07, 5'h04, 1);
        addRow("mfc0 in M", 8, 9, 0, decNone, reqNone, selM2, selM, 7'h00, 5'h00, 0);
        // r9 sits in M2 and r8 in W and both must hold through the stalls
        addRow("dcache hold", 9, 8, 11, decWrite, reqDCache, selM2, selW, 7'h7f, 5'h00, 0);
        addRow("icache hold", 9, 8, 11, decWrite, reqICache, selM2, selW, 7'h7f, 5'h00, 0);
        addRow("alu hold", 9, 8, 11, decWrite, reqAlu, selM2, selW, 7'h7f, 5'h00, 0);
        addRow("stall off", 9, 8, 11, decWrite, reqNone, selM2, selW, 7'h00, 5'h00, 0);
        addRow("exception", 11, 9, 12, decWrite, reqExc, selE, selW, 7'h00, 5'h1f, 0);
        addRow("exc cache", 0, 0, 0, decNone, reqExc | reqDCache, selNone, selNone,
               7'h3e, 5'h1f, 0);
        addRow("mispredict", 0, 0, 0, decNone, reqMispred, selNone, selNone, 7'h00, 5'h03, 0);
        addRow("mispred D stl", 0, 0, 0, decNone, reqMispred | reqBlank, selNone, selNone,
               7'h1f, 5'h11, 0);
        addRow("jump", 0, 0, 0, decNone, reqJump, selNone, selNone, 7'h00, 5'h01, 0);
        addRow("jump F2 stl", 0, 0, 0, decNone, reqJump | reqICache, selNone, selNone,
               7'h7f, 5'h00, 0);
        addRow("taken branch", 0, 0, 0, decNone, reqTaken, selNone, selNone, 7'h00, 5'h01, 0);
        addRow("blank slot", 0, 0, 0, decNone, reqBlank, selNone, selNone, 7'h1f, 5'h10, 0);
        addRow("blank M2 stl", 0, 0, 0, decNone, reqBlank | reqAlu, selNone, selNone,
               7'h7f, 5'h00, 0);
        addRow("idle", 3, 4, 0, decNone, reqNone, selNone, selNone, 7'h00, 5'h00, 0);
    endtask

    task automatic applyRow(input testRow row);
        {srcA, srcB, dstD} = {row.srcA, row.srcB, row.dstD};
        {regWriteD, memReadD, isMfcD} = row.dec;
        {iCacheStall, dCacheStall, aluStallE, blankSl} = row.req[7:4];
        {jumpD, predTakeD, flushPredFailedE, flushExceptionM} = row.req[3:0];
        regFileA = $urandom;
        regFileB = $urandom;
        resultE  = $urandom;
        resultM  = $urandom;
        resultM2 = $urandom;
        resultW  = $urandom;
    endtask

    // word a decode operand should see for a given select
    function automatic regPkg::dataWord wordFor(input ctrlPkg::fwdSel sel,
                                                input regPkg::dataWord fileWord);
        if (sel == selE) return resultE;
        if (sel == selM) return resultM;
        if (sel == selM2) return resultM2;
        if (sel == selW) return resultW;
        return fileWord;
    endfunction

    task automatic checkRow(input string name, input testRow row);
        logic expLongest;
        logic expIcacheCtl;
        expLongest   = (row.req & (reqICache | reqDCache | reqAlu)) != 0;
        expIcacheCtl = ((row.req & (reqDCache | reqAlu | reqBlank)) != 0) || row.expLoadUse;
        checkSel(name, "fwdSelA", row.expSelA, fwdSelA);
        checkSel(name, "fwdSelB", row.expSelB, fwdSelB);
        checkWord(name, "operandA", wordFor(row.expSelA, regFileA), operandA);
        checkWord(name, "operandB", wordFor(row.expSelB, regFileB), operandB);
        checkStall(name, row.expStall, stall);
        checkFlush(name, row.expFlush, flush);
        checkBit(name, "loadUseStall", row.expLoadUse, loadUseStall);
        checkBit(name, "longestStall", expLongest, longestStall);
        checkBit(name, "icacheCtl", expIcacheCtl, icacheCtl);
    endtask

    initial begin
        int unsigned seedValue;
        seedValue = $urandom(32'h71a8_7301);
        rstN = 1'b0;
        applyRow('0);
        buildTable();
        tableBuilt = 1'b1;
        repeat (2) @(posedge clk);
        #(driveDelay);
        rstN = 1'b1;
        for (int idx = 0; idx < rows.size(); idx++) begin
            applyRow(rows[idx]);
            #(sampleWait);
            checkRow(rowNames[idx], rows[idx]);
            @(posedge clk);
            #(driveDelay);
        end
        $display("rows: %0d, checks: %0d, errors: %0d", rows.size(), checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        int timeLimit;
        wait (tableBuilt);
        timeLimit = (rows.size() + 10) * clkPeriod;
        #(timeLimit);
        $display("simulation timed out after %0d ns, the row loop never finished", timeLimit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- rtl/pipeCtrlTop.sv
`timescale 1ns/1ns

module pipeCtrlTop (
    input  logic              clk,
    input  logic              rstN,

    // decode instruction
    input  regPkg::regAddr    srcA,
    input  regPkg::regAddr    srcB,
    input  regPkg::regAddr    dstD,
    input  logic              regWriteD,
    input  logic              memReadD,
    input  logic              isMfcD,

    input  logic              iCacheStall,
    input  logic              dCacheStall,
    input  logic              aluStallE,
    input  logic              blankSl,

    input  logic              jumpD,
    input  logic              predTakeD,
    input  logic              flushPredFailedE,
    input  logic              flushExceptionM,

    input  regPkg::dataWord   regFileA,
    input  regPkg::dataWord   regFileB,
    input  regPkg::dataWord   resultE,
    input  regPkg::dataWord   resultM,
    input  regPkg::dataWord   resultM2,
    input  regPkg::dataWord   resultW,

    output ctrlPkg::stallMask stall,
    output ctrlPkg::flushMask flush,
    output ctrlPkg::fwdSel    fwdSelA,
    output ctrlPkg::fwdSel    fwdSelB,
    output regPkg::dataWord   operandA,
    output regPkg::dataWord   operandB,
    output logic              loadUseStall,
    output logic              longestStall,
    output logic              icacheCtl
);

    destIf destBus ();

    destPipe destPipe_i (
        .clk       (clk),
        .rstN      (rstN),
        .dstD      (dstD),
        .regWriteD (regWriteD),
        .memReadD  (memReadD),
        .isMfcD    (isMfcD),
        .stall     (stall),
        .flush     (flush),
        .dest      (destBus.src)
    );

    hazardUnit hazardUnit_i (
        .srcA             (srcA),
        .srcB             (srcB),
        .dest             (destBus.sink),
        .iCacheStall      (iCacheStall),
        .dCacheStall      (dCacheStall),
        .aluStallE        (aluStallE),
        .blankSl          (blankSl),
        .jumpD            (jumpD),
        .predTakeD        (predTakeD),
        .flushPredFailedE (flushPredFailedE),
        .flushExceptionM  (flushExceptionM),
        .fwdSelA          (fwdSelA),
        .fwdSelB          (fwdSelB),
        .stall            (stall),
        .flush            (flush),
        .loadUseStall     (loadUseStall),
        .longestStall     (longestStall),
        .icacheCtl        (icacheCtl)
    );

    operandForward operandForward_i (
        .fwdSelA  (fwdSelA),
        .fwdSelB  (fwdSelB),
        .regFileA (regFileA),
        .regFileB (regFileB),
        .resultE  (resultE),
        .resultM  (resultM),
        .resultM2 (resultM2),
        .resultW  (resultW),
        .operandA (operandA),
        .operandB (operandB)
    );

endmodule

//--- rtl/operandForward.sv
`timescale 1ns/1ns

module operandForward (
    input  ctrlPkg::fwdSel  fwdSelA,
    input  ctrlPkg::fwdSel  fwdSelB,
    input  regPkg::dataWord regFileA,
    input  regPkg::dataWord regFileB,
    input  regPkg::dataWord resultE,
    input  regPkg::dataWord resultM,
    input  regPkg::dataWord resultM2,
    input  regPkg::dataWord resultW,
    output regPkg::dataWord operandA,
    output regPkg::dataWord operandB
);

    function automatic regPkg::dataWord selectOperand(
        input ctrlPkg::fwdSel  sel,
        input regPkg::dataWord fromFile,
        input regPkg::dataWord fromE,
        input regPkg::dataWord fromM,
        input regPkg::dataWord fromM2,
        input regPkg::dataWord fromW
    );
        regPkg::dataWord word;
        case (sel)
            ctrlPkg::fwdE:  word = fromE;
            ctrlPkg::fwdM:  word = fromM;
            ctrlPkg::fwdM2: word = fromM2;
            ctrlPkg::fwdW:  word = fromW;
            default:        word = fromFile;  // fwdNone and unused codes
        endcase
        return word;
    endfunction

    assign operandA = selectOperand(fwdSelA, regFileA, resultE, resultM, resultM2, resultW);
    assign operandB = selectOperand(fwdSelB, regFileB, resultE, resultM, resultM2, resultW);

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  regPkg::regAddr    srcA,
    input  regPkg::regAddr    srcB,
    destIf.sink               dest,
    input  logic              iCacheStall,
    input  logic              dCacheStall,
    input  logic              aluStallE,
    input  logic              blankSl,
    input  logic              jumpD,
    input  logic              predTakeD,
    input  logic              flushPredFailedE,
    input  logic              flushExceptionM,
    output ctrlPkg::fwdSel    fwdSelA,
    output ctrlPkg::fwdSel    fwdSelB,
    output ctrlPkg::stallMask stall,
    output ctrlPkg::flushMask flush,
    output logic              loadUseStall,
    output logic              longestStall,
    output logic              icacheCtl
);

    logic cacheStall;
    logic frontStall;   // F, F2, D
    logic midStall;     // E, M
    logic tailStall;    // M2, W
    logic useE;
    logic useM;

    // youngest writer wins, E first
    function automatic ctrlPkg::fwdSel pickSource(
        input regPkg::regAddr src,
        input logic           wrE,
        input regPkg::regAddr regE,
        input logic           wrM,
        input regPkg::regAddr regM,
        input logic           wrM2,
        input regPkg::regAddr regM2,
        input logic           wrW,
        input regPkg::regAddr regW
    );
        ctrlPkg::fwdSel sel;
        sel = ctrlPkg::fwdNone;
        if (src != regPkg::regZero) begin
            if (wrE && src == regE)
                sel = ctrlPkg::fwdE;
            else if (wrM && src == regM)
                sel = ctrlPkg::fwdM;
            else if (wrM2 && src == regM2)
                sel = ctrlPkg::fwdM2;
            else if (wrW && src == regW)
                sel = ctrlPkg::fwdW;
        end
        return sel;
    endfunction

    assign fwdSelA = pickSource(srcA, dest.regWriteE, dest.writeRegE, dest.regWriteM,
                                dest.writeRegM, dest.regWriteM2, dest.writeRegM2,
                                dest.regWriteW, dest.writeRegW);
    assign fwdSelB = pickSource(srcB, dest.regWriteE, dest.writeRegE, dest.regWriteM,
                                dest.writeRegM, dest.regWriteM2, dest.writeRegM2,
                                dest.regWriteW, dest.writeRegW);

    assign useE = (fwdSelA == ctrlPkg::fwdE) || (fwdSelB == ctrlPkg::fwdE);
    assign useM = (fwdSelA == ctrlPkg::fwdM) || (fwdSelB == ctrlPkg::fwdM);

    // load data only exists after M, cp0 read data after E
    assign loadUseStall = (useE && (dest.memReadE || dest.isMfcE)) || (useM && dest.memReadM);

    assign cacheStall   = iCacheStall | dCacheStall;
    assign tailStall    = cacheStall | aluStallE;
    assign midStall     = tailStall | blankSl;
    assign frontStall   = midStall | loadUseStall;
    assign longestStall = tailStall;
    assign icacheCtl    = dCacheStall | aluStallE | loadUseStall | blankSl;

    always_comb begin
        stall = '0;
        stall[ctrlPkg::stallF]  = frontStall & ~flushExceptionM;  // refetch from handler
        stall[ctrlPkg::stallF2] = frontStall;
        stall[ctrlPkg::stallD]  = frontStall;
        stall[ctrlPkg::stallE]  = midStall;
        stall[ctrlPkg::stallM]  = midStall;
        stall[ctrlPkg::stallM2] = tailStall;
        stall[ctrlPkg::stallW]  = tailStall & ~flushExceptionM;
    end

    always_comb begin
        flush = '0;
        flush[ctrlPkg::flushF2] = flushExceptionM | flushPredFailedE
                                  | ((jumpD | predTakeD) & ~stall[ctrlPkg::stallF2]);
        flush[ctrlPkg::flushD]  = flushExceptionM | (flushPredFailedE & ~stall[ctrlPkg::stallD]);
        // bubble into E while D waits for the load
        flush[ctrlPkg::flushE]  = flushExceptionM | (loadUseStall & ~stall[ctrlPkg::stallE]);
        flush[ctrlPkg::flushM]  = flushExceptionM;
        flush[ctrlPkg::flushM2] = flushExceptionM | (blankSl & ~stall[ctrlPkg::stallM2]);
    end

    always_comb begin
        zeroNeverForwards: assert final (
            (srcA != regPkg::regZero || fwdSelA == ctrlPkg::fwdNone) &&
            (srcB != regPkg::regZero || fwdSelB == ctrlPkg::fwdNone)
        );
        backStallsOrdered: assert final (
            !stall[ctrlPkg::stallM2] || (stall[ctrlPkg::stallE] && stall[ctrlPkg::stallM])
        );
    end

endmodule

//--- rtl/destPipe.sv
`timescale 1ns/1ns

module destPipe (
    input  logic              clk,
    input  logic              rstN,
    input  regPkg::regAddr    dstD,
    input  logic              regWriteD,
    input  logic              memReadD,
    input  logic              isMfcD,
    input  ctrlPkg::stallMask stall,
    input  ctrlPkg::flushMask flush,
    destIf.src                dest
);

    logic advE;
    logic advM;
    logic advM2;
    logic advW;

    // a stage takes the record of the stage before it unless stalled
    assign advE  = ~stall[ctrlPkg::stallE];
    assign advM  = ~stall[ctrlPkg::stallM];
    assign advM2 = ~stall[ctrlPkg::stallM2];
    assign advW  = ~stall[ctrlPkg::stallW];

    // flush wins over stall for the control bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dest.regWriteE  <= 1'b0;
            dest.memReadE   <= 1'b0;
            dest.isMfcE     <= 1'b0;
            dest.regWriteM  <= 1'b0;
            dest.memReadM   <= 1'b0;
            dest.regWriteM2 <= 1'b0;
            dest.regWriteW  <= 1'b0;
        end else begin
            if (flush[ctrlPkg::flushE]) begin
                dest.regWriteE <= 1'b0;
                dest.memReadE  <= 1'b0;
                dest.isMfcE    <= 1'b0;
            end else if (advE) begin
                dest.regWriteE <= regWriteD;
                dest.memReadE  <= memReadD;
                dest.isMfcE    <= isMfcD;
            end

            if (flush[ctrlPkg::flushM]) begin
                dest.regWriteM <= 1'b0;
                dest.memReadM  <= 1'b0;
            end else if (advM) begin
                dest.regWriteM <= dest.regWriteE;
                dest.memReadM  <= dest.memReadE;  // mfc0 data is ready by M
            end

            if (flush[ctrlPkg::flushM2]) begin
                dest.regWriteM2 <= 1'b0;
            end else if (advM2) begin
                dest.regWriteM2 <= dest.regWriteM;
            end

            if (advW) begin  // W has no flush
                dest.regWriteW <= dest.regWriteM2;
            end
        end
    end

    // register numbers are only looked at while the matching regWrite is high
    always_ff @(posedge clk) begin
        if (advE) begin
            dest.writeRegE <= dstD;
        end
        if (advM) begin
            dest.writeRegM <= dest.writeRegE;
        end
        if (advM2) begin
            dest.writeRegM2 <= dest.writeRegM;
        end
        if (advW) begin
            dest.writeRegW <= dest.writeRegM2;
        end
    end

    // a bubble pushed into E must not look like a writer to the hazard logic
    flushEKillsWrite: assert property (
        @(posedge clk) disable iff (!rstN)
        flush[ctrlPkg::flushE] |=> !dest.regWriteE
    );

endmodule

//--- rtl/destIf.sv
`timescale 1ns/1ns

// destination tracking bundle, one record per stage from E to W
interface destIf;

    logic           regWriteE;
    regPkg::regAddr writeRegE;
    logic           regWriteM;
    regPkg::regAddr writeRegM;
    logic           regWriteM2;
    regPkg::regAddr writeRegM2;
    logic           regWriteW;
    regPkg::regAddr writeRegW;

    logic memReadE;   // load in E
    logic memReadM;   // load in M
    logic isMfcE;     // cp0 read in E, result only ready after E

    modport src (
        output regWriteE, writeRegE, regWriteM, writeRegM,
        output regWriteM2, writeRegM2, regWriteW, writeRegW,
        output memReadE, memReadM, isMfcE
    );

    modport sink (
        input regWriteE, writeRegE, regWriteM, writeRegM,
        input regWriteM2, writeRegM2, regWriteW, writeRegW,
        input memReadE, memReadM, isMfcE
    );

endinterface

//--- rtl/ctrlPkg.sv
package ctrlPkg;

    // forwarding source for a decode operand
    typedef logic [2:0] fwdSel;

    localparam fwdSel fwdNone = 3'd0;  // take register file
    localparam fwdSel fwdW    = 3'd1;
    localparam fwdSel fwdM2   = 3'd2;
    localparam fwdSel fwdM    = 3'd3;
    localparam fwdSel fwdE    = 3'd4;

    // one stall bit per stage, F in bit 0 up to W in bit 6
    typedef logic [6:0] stallMask;

    // F and W never flush, so only five bits
    typedef logic [4:0] flushMask;

    localparam int stallF  = 0;
    localparam int stallF2 = 1;
    localparam int stallD  = 2;
    localparam int stallE  = 3;
    localparam int stallM  = 4;
    localparam int stallM2 = 5;
    localparam int stallW  = 6;

    localparam int flushF2 = 0;
    localparam int flushD  = 1;
    localparam int flushE  = 2;
    localparam int flushM  = 3;
    localparam int flushM2 = 4;

endpackage

//--- rtl/regPkg.sv
package regPkg;

    localparam int regAddrWidth = 5;
    localparam int dataWidth    = 32;

    // architectural register number
    typedef logic [regAddrWidth-1:0] regAddr;

    // operand or result word
    typedef logic [dataWidth-1:0] dataWord;

    // $zero is hardwired, never a forwarding target
    localparam regAddr regZero = '0;

endpackage
